// File: Bender.yml
package:
  name: ppu_bg_render

sources:
  - files:
      - common/ppu_pkg.sv
      - rtl/ppu_scan_timer.sv
      - bg/ppu_bg_fetch.sv
      - bg/ppu_bg_shifter.sv
      - rtl/ppu_vbuf_writer.sv
      - rtl/ppu_bg_render.sv
  - target: test
    files:
      - tb/ppu_bg_render_properties.sv
      - tb/ppu_bg_render_tb.sv

// File: bg/ppu_bg_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module ppu_bg_fetch
    import ppu_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rstn,
    input  bg_cfg_t     i_cfg,
    input  scan_pos_t   i_pos,
    input  logic [7:0]  i_nt_rdata,
    output logic [11:0] o_nt_addr,
    output logic [11:0] o_pt_addr,
    output logic [1:0]  o_quad
);

    logic [4:0] r_coarse_x;
    logic [4:0] r_coarse_y;
    logic [2:0] r_fine_y;
    logic [1:0] r_nt_base;
    logic       c_calc;
    logic [2:0] c_step;
    logic [9:0] c_tile_addr;
    logic [9:0] c_attr_addr;
    logic       c_v_reload;
    logic       c_h_reload;

    assign c_calc     = pixel_calc(i_pos);
    assign c_step     = i_pos.x[2:0];                       // step within a tile
    assign c_v_reload = (i_pos.y == SCAN_Y_MAX) && (i_pos.x == 9'h10f);
    assign c_h_reload = (i_pos.x == 9'h101);

    ////////////////////////////////////////
    // vertical scroll
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_coarse_y   <= '0;
            r_fine_y     <= '0;
            r_nt_base[1] <= 1'b0;
        end else if (c_v_reload) begin
            r_coarse_y   <= i_cfg.coarse_y;
            r_fine_y     <= i_cfg.fine_y;
            r_nt_base[1] <= i_cfg.nt_base[1];
        end else if (i_pos.x == 9'h100) begin
            r_fine_y <= r_fine_y + 3'd1;
            if (r_fine_y == 3'd7) begin
                if (r_coarse_y == NT_ROWS - 5'd1) begin
                    r_coarse_y   <= '0;
                    r_nt_base[1] <= ~r_nt_base[1];  // next table down
                end else begin
                    r_coarse_y <= r_coarse_y + 5'd1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // horizontal scroll
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_coarse_x   <= '0;
            r_nt_base[0] <= 1'b0;
        end else if (c_h_reload) begin
            r_coarse_x   <= i_cfg.coarse_x;
            r_nt_base[0] <= i_cfg.nt_base[0];
        end else if (c_calc && c_step == 3'd7) begin
            r_coarse_x <= r_coarse_x + 5'd1;
            if (r_coarse_x == 5'd31) begin
                r_nt_base[0] <= ~r_nt_base[0];      // next table across
            end
        end
    end

    assign c_tile_addr = {r_coarse_y, r_coarse_x};
    assign c_attr_addr = {ATTR_BASE, r_coarse_y[4:2], r_coarse_x[4:2]};

    // tile index at step 5, attribute byte at step 6
    always_comb begin
        o_nt_addr = {r_nt_base, 10'h0};
        if (c_calc && c_step == 3'd5) begin
            o_nt_addr[9:0] = c_tile_addr;
        end else if (c_calc && c_step == 3'd6) begin
            o_nt_addr[9:0] = c_attr_addr;
        end
    end

    // tile index is back from the name table at step 6
    assign o_pt_addr = (c_calc && c_step == 3'd6) ? {i_cfg.bg_pt_sel, i_nt_rdata, r_fine_y}
                                                  : 12'h0;

    assign o_quad = {r_coarse_y[1], r_coarse_x[1]};

endmodule

`default_nettype wire

// File: bg/ppu_bg_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module ppu_bg_shifter
    import ppu_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rstn,
    input  bg_cfg_t     i_cfg,
    input  scan_pos_t   i_pos,
    input  logic [1:0]  i_quad,
    input  logic [7:0]  i_nt_rdata,
    input  logic [15:0] i_pt_rdata,
    output logic [4:0]  o_plt_addr
);

    // lanes 3..0 are attribute high, attribute low, pattern high, pattern low
    logic [3:0][15:0] r_shft;
    logic [3:0][7:0]  c_load_byte;
    logic [1:0]       c_attr_pair;
    logic             c_calc;
    logic             c_load;
    logic [3:0]       c_tap;
    logic [3:0]       c_raw_pixel;
    logic             c_hide;
    logic [3:0]       c_bg_pixel;

    assign c_calc = pixel_calc(i_pos);
    assign c_load = (i_pos.x[2:0] == 3'd7);

    // attribute byte packs four 2-bit palettes
    assign c_attr_pair = i_nt_rdata[{i_quad, 1'b0} +: 2];

    assign c_load_byte[3] = {8{c_attr_pair[1]}};
    assign c_load_byte[2] = {8{c_attr_pair[0]}};
    assign c_load_byte[1] = i_pt_rdata[15:8];
    assign c_load_byte[0] = i_pt_rdata[7:0];

    ////////////////////////////////////////
    // shift registers
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_shft <= '0;
        end else if (c_calc) begin
            for (int i = 0; i < 4; i++) begin
                if (c_load) begin
                    r_shft[i] <= {r_shft[i][14:7], c_load_byte[i]};    // next tile in
                end else begin
                    r_shft[i] <= {r_shft[i][14:0], 1'b0};
                end
            end
        end
    end

    ////////////////////////////////////////
    // pixel select and gating
    ////////////////////////////////////////
    assign c_tap = 4'd15 - {1'b0, i_cfg.fine_x};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            c_raw_pixel[i] = r_shft[i][c_tap];
        end
    end

    assign c_hide     = ~i_cfg.bg_ena | (~i_cfg.bg_clip & (i_pos.x < 9'd8));
    assign c_bg_pixel = c_hide ? 4'h0 : c_raw_pixel;   // backdrop colour

    assign o_plt_addr = {1'b0, c_bg_pixel};             // background palettes only

endmodule

`default_nettype wire

// File: common/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    ////////////////////////////////////////
    // frame geometry
    ////////////////////////////////////////
    localparam logic [8:0] SCAN_X_MAX  = 9'd335;   // last cycle of a scanline
    localparam logic [8:0] SCAN_Y_MAX  = 9'd261;   // pre-render line
    localparam logic [8:0] VISIBLE_H   = 9'd256;   // pixels per line
    localparam logic [8:0] VISIBLE_V   = 9'd240;   // visible lines
    localparam logic [8:0] VBLANK_LINE = 9'd240;   // line loaded at frame start
    localparam logic [4:0] NT_ROWS     = 5'd30;    // tile rows per name table
    localparam logic [3:0] ATTR_BASE   = 4'b1111;  // attribute block prefix

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////
    typedef struct packed {
        logic [8:0] x;  // cycle within line
        logic [8:0] y;  // scanline
    } scan_pos_t;

    typedef struct packed {
        logic [1:0] nt_base;    // base name table
        logic       bg_pt_sel;  // pattern table select
        logic       bg_ena;
        logic       bg_clip;    // 1 shows the left 8 pixels
        logic [4:0] coarse_x;
        logic [2:0] fine_x;
        logic [4:0] coarse_y;
        logic [2:0] fine_y;
        logic [8:0] pad;
    } bg_cfg_t;

    // true on the visible lines and the pre-render line,
    // on pixel cycles and on the two-tile prefetch at 0x110..0x11f
    function automatic logic pixel_calc(input scan_pos_t pos);
        logic line_ok;
        logic cycle_ok;
        line_ok  = (pos.y < VISIBLE_V) || (pos.y == SCAN_Y_MAX);
        cycle_ok = (pos.x < VISIBLE_H) || (pos.x[8:4] == 5'h11);
        return line_ok && cycle_ok;
    endfunction

endpackage

`default_nettype wire

// File: filelist.f
common/ppu_pkg.sv
rtl/ppu_scan_timer.sv
bg/ppu_bg_fetch.sv
bg/ppu_bg_shifter.sv
rtl/ppu_vbuf_writer.sv
rtl/ppu_bg_render.sv
tb/ppu_bg_render_properties.sv
tb/ppu_bg_render_tb.sv

// File: rtl/ppu_bg_render.sv
`timescale 1ns/100ps
`default_nettype none

module ppu_bg_render
    import ppu_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rstn,
    input  logic [7:0]  i_ppuctrl,
    input  logic [7:0]  i_ppumask,
    input  logic [7:0]  i_ppuscroll_x,
    input  logic [7:0]  i_ppuscroll_y,
    input  logic        i_vblank,
    output logic [11:0] o_nt_addr,
    input  logic [7:0]  i_nt_rdata,
    output logic [11:0] o_pt_addr,
    input  logic [15:0] i_pt_rdata,
    output logic [4:0]  o_plt_addr,
    input  logic [7:0]  i_plt_rdata,
    output logic [16:0] o_vbuf_addr,
    output logic        o_vbuf_we,
    output logic [7:0]  o_vbuf_wdata
);

    bg_cfg_t    c_cfg;
    scan_pos_t  scan_pos;
    logic       vbuf_page;
    logic [1:0] attr_quad;

    ////////////////////////////////////////
    // register fields
    ////////////////////////////////////////
    assign c_cfg.nt_base   = i_ppuctrl[1:0];
    assign c_cfg.bg_pt_sel = i_ppuctrl[4];
    assign c_cfg.bg_ena    = i_ppumask[3];
    assign c_cfg.bg_clip   = i_ppumask[1];
    assign c_cfg.coarse_x  = i_ppuscroll_x[7:3];
    assign c_cfg.fine_x    = i_ppuscroll_x[2:0];
    assign c_cfg.coarse_y  = i_ppuscroll_y[7:3];
    assign c_cfg.fine_y    = i_ppuscroll_y[2:0];
    assign c_cfg.pad       = '0;

    ppu_scan_timer ppu_scan_timer_inst (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_vblank      (i_vblank),
        .o_pos         (scan_pos),
        .o_frame_start (),
        .o_page        (vbuf_page)
    );

    ppu_bg_fetch ppu_bg_fetch_inst (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_cfg      (c_cfg),
        .i_pos      (scan_pos),
        .i_nt_rdata (i_nt_rdata),
        .o_nt_addr  (o_nt_addr),
        .o_pt_addr  (o_pt_addr),
        .o_quad     (attr_quad)
    );

    ppu_bg_shifter ppu_bg_shifter_inst (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_cfg      (c_cfg),
        .i_pos      (scan_pos),
        .i_quad     (attr_quad),
        .i_nt_rdata (i_nt_rdata),
        .i_pt_rdata (i_pt_rdata),
        .o_plt_addr (o_plt_addr)
    );

    ppu_vbuf_writer ppu_vbuf_writer_inst (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_pos        (scan_pos),
        .i_page       (vbuf_page),
        .i_plt_rdata  (i_plt_rdata),
        .o_vbuf_addr  (o_vbuf_addr),
        .o_vbuf_we    (o_vbuf_we),
        .o_vbuf_wdata (o_vbuf_wdata)
    );

endmodule

`default_nettype wire

// File: rtl/ppu_scan_timer.sv
`timescale 1ns/100ps
`default_nettype none

module ppu_scan_timer
    import ppu_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rstn,
    input  logic      i_vblank,
    output scan_pos_t o_pos,
    output logic      o_frame_start,
    output logic      o_page
);

    logic      r_vblank;
    logic      rr_vblank;
    logic      c_frame_start;
    logic      r_run;
    logic      c_line_end;
    scan_pos_t r_pos;
    logic      r_page;

    ////////////////////////////////////////
    // vblank sync and edge
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_vblank  <= 1'b0;
            rr_vblank <= 1'b0;
        end else begin
            r_vblank  <= i_vblank;
            rr_vblank <= r_vblank;
        end
    end

    assign c_frame_start = r_vblank & ~rr_vblank;    // rising edge
    assign c_line_end    = (r_pos.x == SCAN_X_MAX);

    // runs from frame start to the end of the last visible line
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_run <= 1'b0;
        end else if (c_frame_start) begin
            r_run <= 1'b1;
        end else if (c_line_end && r_pos.y == VISIBLE_V - 9'd1) begin
            r_run <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // scan counters
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_pos <= '0;
        end else if (c_frame_start) begin
            r_pos.x <= '0;
            r_pos.y <= VBLANK_LINE;                 // frame opens in vblank
        end else if (r_run) begin
            if (c_line_end) begin
                r_pos.x <= '0;
                r_pos.y <= (r_pos.y == SCAN_Y_MAX) ? 9'd0 : r_pos.y + 9'd1;
            end else begin
                r_pos.x <= r_pos.x + 9'd1;
            end
        end
    end

    // first frame lands on page 1
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_page <= 1'b0;
        end else if (c_frame_start) begin
            r_page <= ~r_page;
        end
    end

    assign o_pos         = r_pos;
    assign o_frame_start = c_frame_start;
    assign o_page        = r_page;

endmodule

`default_nettype wire

// File: rtl/ppu_vbuf_writer.sv
`timescale 1ns/100ps
`default_nettype none

module ppu_vbuf_writer
    import ppu_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rstn,
    input  scan_pos_t   i_pos,
    input  logic        i_page,
    input  logic [7:0]  i_plt_rdata,
    output logic [16:0] o_vbuf_addr,
    output logic        o_vbuf_we,
    output logic [7:0]  o_vbuf_wdata
);

    scan_pos_t r_pos;
    logic      r_armed;

    // position lines up with the palette read data
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_pos   <= '0;
            r_armed <= 1'b0;
        end else begin
            r_pos <= i_pos;
            if (i_pos.y == VISIBLE_V) begin
                r_armed <= 1'b1;    // scan has reached vblank once
            end
        end
    end

    assign o_vbuf_we    = r_armed & (r_pos.y < VISIBLE_V) & (r_pos.x < VISIBLE_H);
    assign o_vbuf_addr  = {i_page, r_pos.y[7:0], r_pos.x[7:0]};
    assign o_vbuf_wdata = i_plt_rdata;

endmodule

`default_nettype wire

// File: tb/ppu_bg_render_properties.sv
`timescale 1ns/100ps
`default_nettype none

module ppu_bg_render_properties
    import ppu_pkg::*;
(
    input logic        i_clk,
    input logic        i_rstn,
    input logic        i_vbuf_we,
    input logic [16:0] i_vbuf_addr
);

    int fail_count = 0;     // failed assertion tally

    a_quiet_in_reset: assert property (@(posedge i_clk) !i_rstn |-> !i_vbuf_we)
        else begin
            $error("frame buffer write while reset is held");
            fail_count++;
        end

    // a row goes left to right one pixel per cycle
    a_row_step: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_vbuf_we && (i_vbuf_addr[7:0] != 8'd0)
        |-> $past(i_vbuf_we) && (i_vbuf_addr == $past(i_vbuf_addr) + 17'd1))
        else begin
            $error("write address did not advance by one pixel");
            fail_count++;
        end

    a_visible: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_vbuf_we |-> ({1'b0, i_vbuf_addr[15:8]} < VISIBLE_V))
        else begin
            $error("write address outside the visible area");
            fail_count++;
        end

endmodule

bind ppu_bg_render ppu_bg_render_properties ppu_bg_render_properties_inst (
    .i_clk       (i_clk),
    .i_rstn      (i_rstn),
    .i_vbuf_we   (o_vbuf_we),
    .i_vbuf_addr (o_vbuf_addr)
);

`default_nettype wire

// File: tb/ppu_bg_render_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ppu_bg_render_tb
    import ppu_pkg::*;
();

    logic        clk;
    logic        rstn;
    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic [7:0]  ppuscroll_x;
    logic [7:0]  ppuscroll_y;
    logic        vblank;
    logic [11:0] nt_addr;
    logic [7:0]  nt_rdata = 8'h00;
    logic [11:0] pt_addr;
    logic [15:0] pt_rdata = 16'h0000;
    logic [4:0]  plt_addr;
    logic [7:0]  plt_rdata = 8'h00;
    logic [16:0] vbuf_addr;
    logic        vbuf_we;
    logic [7:0]  vbuf_wdata;

    logic [7:0]  nt_mem [0:4095];      // four name tables
    logic [15:0] pt_mem [0:4095];      // high plane in bits 15..8
    logic [7:0]  fb [0:131071];        // captured frame buffer, both pages
    logic [7:0]  wr_cnt [0:131071];    // writes per address this frame
    int          total_writes;
    logic        page_exp;
    int          frame_px;
    int          frame_cycles;
    int          line_cycles;
    int unsigned seed_draw;

    ppu_bg_render ppu_bg_render_inst (
        .i_clk         (clk),
        .i_rstn        (rstn),
        .i_ppuctrl     (ppuctrl),
        .i_ppumask     (ppumask),
        .i_ppuscroll_x (ppuscroll_x),
        .i_ppuscroll_y (ppuscroll_y),
        .i_vblank      (vblank),
        .o_nt_addr     (nt_addr),
        .i_nt_rdata    (nt_rdata),
        .o_pt_addr     (pt_addr),
        .i_pt_rdata    (pt_rdata),
        .o_plt_addr    (plt_addr),
        .i_plt_rdata   (plt_rdata),
        .o_vbuf_addr   (vbuf_addr),
        .o_vbuf_we     (vbuf_we),
        .o_vbuf_wdata  (vbuf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // memory models and capture
    ////////////////////////////////////////
    always @(posedge clk) begin
        nt_rdata  <= nt_mem[nt_addr];              // data one edge after the address
        pt_rdata  <= pt_mem[pt_addr];
        plt_rdata <= 8'h40 + {3'b000, plt_addr};   // colour shows its palette address
    end

    always @(negedge clk) begin
        if (vbuf_we === 1'b1) begin
            fb[vbuf_addr]     = vbuf_wdata;
            wr_cnt[vbuf_addr] = wr_cnt[vbuf_addr] + 8'd1;
            total_writes      = total_writes + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(negedge clk) begin
        if (ppu_bg_render_inst.ppu_bg_render_properties_inst.fail_count != 0) begin
            abort_run("a bound assertion on the frame buffer port failed");
        end
    end

    task automatic check_count(input string test, input string what,
                               input int exp, input int got);
        assert (got == exp)
            else abort_run($sformatf("Mismatch in %s: %s expected %0d, actual %0d",
                                     test, what, exp, got));
    endtask

    task automatic load_registers(input logic [7:0] sx, input logic [7:0] sy,
                                  input logic [1:0] base, input logic sel,
                                  input logic ena, input logic clip);
        @(negedge clk);
        ppuctrl     = {3'b000, sel, 2'b00, base};
        ppumask     = {4'b0000, ena, 1'b0, clip, 1'b0};
        ppuscroll_x = sx;
        ppuscroll_y = sy;
    endtask

    // one vblank pulse, then wait for the whole visible area
    task automatic run_frame(input string name);
        int waited;
        for (int a = 0; a < 131072; a++) begin
            wr_cnt[a] = 8'd0;
        end
        total_writes = 0;
        page_exp     = ~page_exp;
        @(negedge clk);
        vblank = 1'b1;
        repeat (4) @(negedge clk);
        vblank = 1'b0;
        waited = 0;
        while (total_writes < frame_px) begin
            @(negedge clk);
            waited++;
            if (waited > 2 * frame_cycles) begin
                abort_run($sformatf("%s: frame did not complete, only %0d writes seen",
                                    name, total_writes));
            end
        end
        repeat (2 * line_cycles) @(negedge clk);    // quiet tail after the last line
        check_count(name, "frame writes", frame_px, total_writes);
    endtask

    ////////////////////////////////////////
    // reference pixel
    ////////////////////////////////////////
    function automatic logic [7:0] expected_pixel(input int x, input int y);
        int          wx;
        int          wy;
        int          tbl;
        int          col;
        int          row;
        logic [7:0]  tile;
        logic [7:0]  attr;
        logic [15:0] pat;
        logic [1:0]  pal;
        wx  = x + ppuscroll_x;
        wy  = y + ppuscroll_y;
        tbl = ppuctrl[1:0];
        if (wx >= 256) begin
            wx  = wx - 256;
            tbl = tbl ^ 1;      // table to the right
        end
        if (wy >= 240) begin
            wy  = wy - 240;
            tbl = tbl ^ 2;      // table below
        end
        col  = wx / 8;
        row  = wy / 8;
        tile = nt_mem[tbl * 1024 + row * 32 + col];
        attr = nt_mem[tbl * 1024 + 960 + (row / 4) * 8 + col / 4];
        pal  = attr[((row / 2) % 2) * 4 + ((col / 2) % 2) * 2 +: 2];
        pat  = pt_mem[ppuctrl[4] * 2048 + tile * 8 + wy % 8];
        return 8'h40 + {4'h0, pal, pat[15 - wx % 8], pat[7 - wx % 8]};
    endfunction

    task automatic compare_rows(input string name, input int y_step);
        logic [7:0] exp;
        logic [7:0] got;
        logic       hide;
        for (int y = 0; y < 240; y += y_step) begin
            for (int x = 0; x < 256; x++) begin
                hide = !ppumask[3] || (!ppumask[1] && x < 8);
                exp  = hide ? 8'h40 : expected_pixel(x, y);
                got  = fb[{page_exp, y[7:0], x[7:0]}];
                assert (got == exp)
                    else abort_run($sformatf(
                        "Mismatch in %s: pixel (%0d,%0d) expected 0x%0h, actual 0x%0h",
                        name, x, y, exp, got));
            end
        end
    endtask

    task automatic verify_write_counts(input string name);
        int exp;
        int got;
        for (int p = 0; p < 2; p++) begin
            for (int y = 0; y < 240; y++) begin
                for (int x = 0; x < 256; x++) begin
                    exp = (p == int'(page_exp)) ? 1 : 0;
                    got = wr_cnt[{p[0], y[7:0], x[7:0]}];
                    assert (got == exp)
                        else abort_run($sformatf(
                            "Mismatch in %s: page %0d (%0d,%0d) writes expected %0d, actual %0d",
                            name, p, x, y, exp, got));
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic reset_quiet();
        repeat (8) begin
            @(negedge clk);
            assert (vbuf_we == 1'b0)
                else abort_run("frame buffer write strobe went high while reset was held");
        end
        rstn = 1'b1;
        repeat (400) @(negedge clk);
        check_count("reset_quiet", "writes before vblank", 0, total_writes);
    endtask

    task automatic frame_coverage();
        load_registers(8'h00, 8'h00, 2'b00, 1'b0, 1'b1, 1'b1);
        run_frame("frame_coverage");
        verify_write_counts("frame_coverage");  // page 1
        run_frame("frame_coverage");
        verify_write_counts("frame_coverage");  // back to page 0
    endtask

    task automatic zero_scroll_picture();
        load_registers(8'h00, 8'h00, 2'b00, 1'b1, 1'b1, 1'b1);
        run_frame("zero_scroll_picture");
        compare_rows("zero_scroll_picture", 1);
    endtask

    // both wraps fall inside the picture
    task automatic scrolled_picture();
        load_registers(8'h5b, 8'h6d, 2'b11, 1'b0, 1'b1, 1'b1);
        run_frame("scrolled_picture");
        compare_rows("scrolled_picture", 3);
    endtask

    task automatic clip_and_disable();
        load_registers(8'h23, 8'h11, 2'b01, 1'b1, 1'b1, 1'b0);
        run_frame("clip_off");
        compare_rows("clip_off", 1);
        load_registers(8'h23, 8'h11, 2'b01, 1'b1, 1'b0, 1'b1);
        run_frame("bg_disabled");
        compare_rows("bg_disabled", 1);
    endtask

    initial begin
        seed_draw    = $urandom(32'h8d0c);
        rstn         = 1'b0;
        vblank       = 1'b0;
        ppuctrl      = 8'h00;
        ppumask      = 8'h00;
        ppuscroll_x  = 8'h00;
        ppuscroll_y  = 8'h00;
        total_writes = 0;
        page_exp     = 1'b0;
        frame_px     = int'(VISIBLE_H) * int'(VISIBLE_V);
        line_cycles  = int'(SCAN_X_MAX) + 1;
        frame_cycles = line_cycles * (int'(SCAN_Y_MAX) + 1);
        for (int i = 0; i < 4096; i++) begin
            nt_mem[i] = 8'($urandom());
            pt_mem[i] = 16'($urandom());
        end
        reset_quiet();
        frame_coverage();
        zero_scroll_picture();
        scrolled_picture();
        clip_and_disable();
        if (ppu_bg_render_inst.ppu_bg_render_properties_inst.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run($sformatf("bound assertions failed %0d times",
                                ppu_bg_render_inst.ppu_bg_render_properties_inst.fail_count));
        end
    end

endmodule

`default_nettype wire
